// ==== Makefile ====
# Verilator build and run for the multiplier farm testbench

VERILATOR ?= verilator
TOP       ?= imul_farm_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# passes only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
hw/imul_pkg.sv
hw/imul_iterative.sv
hw/imul_dispatch.sv
hw/imul_collect.sv
hw/imul_farm.sv
verification/imul_farm_checker.sv
verification/imul_farm_tb.sv

// ==== hw/imul_collect.sv ====
// result collector
// drains units in round-robin order, four-phase sender for the products

`timescale 1ns/1ps

module imul_collect import imul_pkg::*; #(
  parameter int NUM_UNITS = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [NUM_UNITS-1:0]      unit_resp_val,
  output logic [NUM_UNITS-1:0]      unit_resp_rdy,
  input  mul_resp_t [NUM_UNITS-1:0] unit_resp_msg,
  output logic                      out_req,
  input  logic                      out_ack,
  output mul_resp_t                 out_msg
);

  localparam int ptr_w = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

  // wait for a product, send it, then wait for ack to return low
  typedef enum logic [1:0] {
    COL_WAIT    = 2'd0,
    COL_SEND    = 2'd1,
    COL_RELEASE = 2'd2
  } col_state_e;

  col_state_e       state;
  logic [ptr_w-1:0] ptr;
  logic             take;

  // only the unit under the pointer is ever drained
  assign take          = (state == COL_WAIT) && unit_resp_val[ptr];
  assign unit_resp_rdy = take ? (NUM_UNITS'(1) << ptr) : '0;

  // req is high for exactly the send phase
  assign out_req = (state == COL_SEND);

  // ---------------------------------------------------------------------
  // four-phase send and pointer
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= COL_WAIT;
      ptr   <= '0;
    end else begin
      case (state)
        COL_WAIT: begin
          if (take) begin
            state <= COL_SEND;
          end
        end
        COL_SEND: begin
          if (out_ack) begin
            state <= COL_RELEASE;
          end
        end
        COL_RELEASE: begin
          // handshake complete, move on to the next unit
          if (!out_ack) begin
            state <= COL_WAIT;
            if (ptr == ptr_w'(NUM_UNITS - 1)) begin
              ptr <= '0;
            end else begin
              ptr <= ptr + ptr_w'(1);
            end
          end
        end
        default: state <= COL_WAIT;
      endcase
    end
  end

  // output register, stable for the whole send phase
  always_ff @(posedge clk) begin
    if (take) begin
      out_msg <= unit_resp_msg[ptr];
    end
  end

endmodule

// ==== hw/imul_dispatch.sv ====
// request dispatcher
// four-phase receiver, issues each request to the next unit in turn

`timescale 1ns/1ps

module imul_dispatch import imul_pkg::*; #(
  parameter int NUM_UNITS = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_req,
  output logic                 in_ack,
  input  mul_req_t             in_msg,
  output logic [NUM_UNITS-1:0] unit_req_val,
  input  logic [NUM_UNITS-1:0] unit_req_rdy,
  output mul_req_t             unit_req_msg
);

  // pointer needs at least one bit even for a single unit
  localparam int ptr_w = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

  logic [ptr_w-1:0] ptr;
  logic             issuing;
  logic             issue;

  // a val pulse is in flight this cycle
  assign issuing = |unit_req_val;

  // new request, not yet acked, and the unit under the pointer is idle
  assign issue = in_req && !in_ack && !issuing && unit_req_rdy[ptr];

  // ---------------------------------------------------------------------
  // handshake and round-robin pointer
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      in_ack       <= 1'b0;
      unit_req_val <= '0;
      ptr          <= '0;
    end else begin
      // val is a one-cycle pulse to the selected unit only
      unit_req_val <= '0;
      if (issue) begin
        unit_req_val <= NUM_UNITS'(1) << ptr;
      end

      if (issuing) begin
        // the unit was idle when picked, so it takes the pulse for sure
        in_ack <= 1'b1;
        if (ptr == ptr_w'(NUM_UNITS - 1)) begin
          ptr <= '0;
        end else begin
          ptr <= ptr + ptr_w'(1);
        end
      end else if (in_ack && !in_req) begin
        // return-to-zero phase
        in_ack <= 1'b0;
      end
    end
  end

  // request payload, shared by all units
  always_ff @(posedge clk) begin
    if (issue) begin
      unit_req_msg <= in_msg;
    end
  end

endmodule

// ==== hw/imul_farm.sv ====
// multiplier farm top level
// dispatcher, NUM_UNITS iterative units and an in-order collector

`timescale 1ns/1ps

module imul_farm import imul_pkg::*; #(
  parameter int NUM_UNITS = 4
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      in_req,
  output logic      in_ack,
  input  mul_req_t  in_msg,
  output logic      out_req,
  input  logic      out_ack,
  output mul_resp_t out_msg
);

  // per-unit val/rdy links
  logic [NUM_UNITS-1:0]      unit_req_val;
  logic [NUM_UNITS-1:0]      unit_req_rdy;
  logic [NUM_UNITS-1:0]      unit_resp_val;
  logic [NUM_UNITS-1:0]      unit_resp_rdy;
  // one request bus fans out, val selects the unit
  mul_req_t                  unit_req_msg;
  mul_resp_t [NUM_UNITS-1:0] unit_resp_msg;

  imul_dispatch #(
    .NUM_UNITS(NUM_UNITS)
  ) i_dispatch (
    .clk          (clk),
    .reset        (reset),
    .in_req       (in_req),
    .in_ack       (in_ack),
    .in_msg       (in_msg),
    .unit_req_val (unit_req_val),
    .unit_req_rdy (unit_req_rdy),
    .unit_req_msg (unit_req_msg)
  );

  for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
    imul_iterative i_unit (
      .clk      (clk),
      .reset    (reset),
      .req_val  (unit_req_val[i]),
      .req_rdy  (unit_req_rdy[i]),
      .req_msg  (unit_req_msg),
      .resp_val (unit_resp_val[i]),
      .resp_rdy (unit_resp_rdy[i]),
      .resp_msg (unit_resp_msg[i])
    );
  end

  imul_collect #(
    .NUM_UNITS(NUM_UNITS)
  ) i_collect (
    .clk           (clk),
    .reset         (reset),
    .unit_resp_val (unit_resp_val),
    .unit_resp_rdy (unit_resp_rdy),
    .unit_resp_msg (unit_resp_msg),
    .out_req       (out_req),
    .out_ack       (out_ack),
    .out_msg       (out_msg)
  );

endmodule

// ==== hw/imul_iterative.sv ====
// iterative shift-and-add multiplier unit
// signed or unsigned 32x32 multiply in 32 steps, val/rdy on both sides

`timescale 1ns/1ps

module imul_iterative import imul_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      req_val,
  output logic      req_rdy,
  input  mul_req_t  req_msg,
  output logic      resp_val,
  input  logic      resp_rdy,
  output mul_resp_t resp_msg
);

  // enough bits to count operand_w steps
  localparam int step_w = $clog2(operand_w);

  unit_state_e          state;
  logic [step_w-1:0]    step;
  logic                 req_go;
  logic                 resp_go;
  logic                 load_en;
  logic                 shift_en;
  logic                 is_signed;
  logic                 sign_a;
  logic                 sign_b;
  logic [operand_w-1:0] mag_a;
  logic [operand_w-1:0] mag_b;
  logic [result_w-1:0]  mcand;
  logic [operand_w-1:0] mplier;
  logic [result_w-1:0]  acc;
  logic                 neg;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ---------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= UNIT_IDLE;
      step  <= '0;
    end else begin
      case (state)
        UNIT_IDLE: begin
          // accept in the handshake cycle, count restarts at zero
          if (req_go) begin
            state <= UNIT_CALC;
            step  <= '0;
          end
        end
        UNIT_CALC: begin
          step <= step + step_w'(1);
          // last add/shift step, product is ready next cycle
          if (step == step_w'(operand_w - 1)) begin
            state <= UNIT_DONE;
          end
        end
        UNIT_DONE: begin
          // hold the product until the collector takes it
          if (resp_go) begin
            state <= UNIT_IDLE;
          end
        end
        default: state <= UNIT_IDLE;
      endcase
    end
  end

  // handshake outputs and datapath enables, decoded from state
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    load_en  = 1'b0;
    shift_en = 1'b0;
    case (state)
      UNIT_IDLE: begin
        req_rdy = 1'b1;
        load_en = req_val;
      end
      UNIT_CALC: shift_en = 1'b1;
      UNIT_DONE: resp_val = 1'b1;
      default: ;
    endcase
  end

  // ---------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------

  // unsigned ops never see a sign bit
  assign is_signed = (req_msg.op == MUL_SIGNED);
  assign sign_a    = is_signed && req_msg.a[operand_w-1];
  assign sign_b    = is_signed && req_msg.b[operand_w-1];

  // magnitudes; 32'h80000000 maps onto itself, which is still right unsigned
  assign mag_a = sign_a ? (~req_msg.a + 1'b1) : req_msg.a;
  assign mag_b = sign_b ? (~req_msg.b + 1'b1) : req_msg.b;

  always_ff @(posedge clk) begin
    if (load_en) begin
      mcand  <= {{(result_w - operand_w){1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      neg    <= sign_a ^ sign_b;
    end else if (shift_en) begin
      // add the shifted multiplicand when the current multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // restore the sign of the product
  assign resp_msg.result = neg ? (~acc + 1'b1) : acc;

endmodule

// ==== hw/imul_pkg.sv ====
// multiplier farm shared types
// opcodes, unit states and the request/response payloads

package imul_pkg;

  // ---------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------

  // operand width is fixed; step count and sign handling depend on it
  localparam int operand_w = 32;
  // full double-width product
  localparam int result_w = 64;

  // ---------------------------------------------------------------------
  // opcodes and states
  // ---------------------------------------------------------------------

  // two's complement or plain unsigned multiply
  typedef enum logic [0:0] {
    MUL_SIGNED   = 1'b0,
    MUL_UNSIGNED = 1'b1
  } mul_op_e;

  // iterative unit control states
  typedef enum logic [1:0] {
    UNIT_IDLE = 2'd0,
    UNIT_CALC = 2'd1,
    UNIT_DONE = 2'd2
  } unit_state_e;

  // ---------------------------------------------------------------------
  // payloads
  // ---------------------------------------------------------------------

  // operand pair plus opcode, 65 bits
  typedef struct packed {
    mul_op_e              op;
    logic [operand_w-1:0] a;
    logic [operand_w-1:0] b;
  } mul_req_t;

  typedef struct packed {
    logic [result_w-1:0] result;
  } mul_resp_t;

endpackage

// ==== verification/imul_farm_checker.sv ====
// four-phase protocol checker for the farm's external links
// bound into imul_farm to watch both req/ack links

`timescale 1ns/1ps

module imul_farm_checker import imul_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      in_req,
  input logic      in_ack,
  input logic      out_req,
  input logic      out_ack,
  input mul_resp_t out_msg
);

  // count of failed properties
  int assert_fails = 0;

  // ack only answers a request pending in the cycle it was raised
  a_in_ack_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(in_ack) |-> $past(in_req))
    else begin
      assert_fails++;
      $error("in_ack rose while in_req was low");
    end

  // product must not change during the send phase
  a_out_msg_stable: assert property (@(posedge clk) disable iff (reset)
    out_req && $past(out_req) |-> $stable(out_msg))
    else begin
      assert_fails++;
      $error("out_msg changed while out_req was high");
    end

  // req holds until the responder acks
  a_out_req_hold: assert property (@(posedge clk) disable iff (reset)
    out_req && !out_ack |=> out_req)
    else begin
      assert_fails++;
      $error("out_req fell before out_ack rose");
    end

  // return-to-zero has to finish before the next send
  a_out_req_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(out_req) |-> !$past(out_ack))
    else begin
      assert_fails++;
      $error("out_req rose while out_ack was still high");
    end

endmodule

// ==== verification/imul_farm_tb.sv ====
// multiplier farm testbench
// four-phase driver and responder around imul_farm, in-order product model

`timescale 1ns/1ps

module imul_farm_tb import imul_pkg::*; ();

  localparam logic [31:0] seed = 32'h75cf;
  localparam int n_signed   = 30;
  localparam int n_unsigned = 30;
  localparam int n_corner   = 50;
  localparam int n_burst    = 12;
  localparam int total_reqs = n_signed + n_unsigned + n_corner + n_burst;
  // cycles any single wait may take
  localparam int wait_limit = 4000;

  logic      clk;
  logic      reset;
  logic      in_req;
  logic      in_ack;
  mul_req_t  in_msg;
  logic      out_req;
  logic      out_ack;
  mul_resp_t out_msg;

  // expected products in issue order
  logic [63:0] expected_q[$];
  logic [31:0] drv_rng;
  logic [31:0] rsp_rng;
  logic        slow_ack;
  int          errors = 0;
  int          timeouts = 0;
  int          received = 0;

  imul_farm #(
    .NUM_UNITS(4)
  ) i_dut (
    .clk     (clk),
    .reset   (reset),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .in_msg  (in_msg),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_msg (out_msg)
  );

  bind imul_farm imul_farm_checker i_checker (
    .clk     (clk),
    .reset   (reset),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_msg (out_msg)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(inout logic [31:0] state, output logic [31:0] value);
    state = xorshift32(state);
    value = state;
  endtask

  // sign- or zero-extend both operands, the low 64 bits are the product
  function automatic logic [63:0] model_product(input mul_op_e op, input logic [31:0] a,
                                                input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    if (op == MUL_SIGNED) begin
      ea = {{32{a[31]}}, a};
      eb = {{32{b[31]}}, b};
    end else begin
      ea = {32'b0, a};
      eb = {32'b0, b};
    end
    return ea * eb;
  endfunction

  function automatic logic [31:0] corner_value(input int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  // one full four-phase transfer, called on a falling edge
  task automatic send_req(input mul_op_e op, input logic [31:0] a, input logic [31:0] b);
    int n;
    in_msg.op = op;
    in_msg.a  = a;
    in_msg.b  = b;
    expected_q.push_back(model_product(op, a, b));
    in_req = 1'b1;
    n = 0;
    while (!in_ack && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!in_ack) begin
      timeouts++;
      $display("timeout at %0t: in_ack never rose for a request", $time);
    end
    in_req = 1'b0;
    n = 0;
    while (in_ack && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (in_ack) begin
      timeouts++;
      $display("timeout at %0t: in_ack never returned low", $time);
    end
  endtask

  // ----------------------------------------------------------------------
  // responder, random ack delay, slower during the burst
  // ----------------------------------------------------------------------

  initial begin : responder
    int          n;
    int          delay;
    logic [31:0] r;
    logic [63:0] want;
    out_ack = 1'b0;
    rsp_rng = seed;
    n = 0;
    @(negedge clk);
    while (reset && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    while (received < total_reqs) begin
      n = 0;
      while (!out_req && n < wait_limit) begin
        @(negedge clk);
        n++;
      end
      if (!out_req) begin
        timeouts++;
        $display("timeout: out_req never rose, %0d results still due", total_reqs - received);
        break;
      end
      if (expected_q.size() == 0) begin
        errors++;
        $display("out_req rose at %0t with no request outstanding", $time);
      end else begin
        want = expected_q.pop_front();
        check_value("out_msg.result", out_msg.result, want);
      end
      received++;
      draw(rsp_rng, r);
      delay = int'(r[2:0]);
      if (slow_ack) begin
        delay = delay + 24;
      end
      repeat (delay) @(negedge clk);
      out_ack = 1'b1;
      n = 0;
      while (out_req && n < wait_limit) begin
        @(negedge clk);
        n++;
      end
      if (out_req) begin
        timeouts++;
        $display("timeout at %0t: out_req never fell after out_ack", $time);
        break;
      end
      out_ack = 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus and closing summary
  // ----------------------------------------------------------------------

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    int          n;
    reset    = 1'b1;
    in_req   = 1'b0;
    in_msg   = '0;
    slow_ack = 1'b0;
    drv_rng  = seed;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // idle link after reset, nothing may be sent yet
    repeat (6) begin
      @(negedge clk);
      check_value("in_ack", 64'(in_ack), 64'd0);
      check_value("out_req", 64'(out_req), 64'd0);
    end

    // signed products, operands of either sign
    for (int i = 0; i < n_signed; i++) begin
      draw(drv_rng, a);
      draw(drv_rng, b);
      send_req(MUL_SIGNED, a, b);
    end

    // unsigned with the top bits set
    for (int i = 0; i < n_unsigned; i++) begin
      draw(drv_rng, a);
      draw(drv_rng, b);
      send_req(MUL_UNSIGNED, a | 32'h8000_0000, b | 32'hc000_0000);
    end

    // every corner pair under both opcodes
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_req(MUL_SIGNED, corner_value(i), corner_value(j));
        send_req(MUL_UNSIGNED, corner_value(i), corner_value(j));
      end
    end

    // burst against a slow responder fills every unit
    slow_ack = 1'b1;
    for (int i = 0; i < n_burst; i++) begin
      draw(drv_rng, r);
      draw(drv_rng, a);
      draw(drv_rng, b);
      send_req(mul_op_e'(r[0]), a, b);
    end

    n = 0;
    while ((received < total_reqs || out_req || out_ack) && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (received < total_reqs) begin
      timeouts++;
      $display("timeout: only %0d of %0d results came back", received, total_reqs);
    end
    if (expected_q.size() != 0) begin
      errors++;
      $display("%0d expected results never arrived", expected_q.size());
    end
    repeat (4) @(negedge clk);
    // no extra product may follow the last one
    check_value("out_req", 64'(out_req), 64'd0);

    $display("errors: %0d check, %0d timeout, %0d assertion", errors, timeouts,
             i_dut.i_checker.assert_fails);
    if (errors == 0 && timeouts == 0 && i_dut.i_checker.assert_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
